//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= vlog.f
STIM      ?= tb/mem_stim.txt
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv src/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile $(STIM)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- src/data_tim.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module data_tim import mem_access_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  mem0_req,
  input  addr_t mem0_addr,
  input  word_t mem0_wdata,
  input  strb_t mem0_strb,
  output logic  mem0_ready,
  output word_t mem0_rdata,
  input  logic  mem1_req,
  input  addr_t mem1_addr,
  input  word_t mem1_wdata,
  input  strb_t mem1_strb,
  output logic  mem1_ready,
  output word_t mem1_rdata
);

  localparam int BANK_LOG2  = `MEM_DEPTH_LOG2 - 1;
  localparam int BANK_WORDS = 1 << BANK_LOG2;
  localparam int CNT_W      = $clog2(`MEM_WAIT + 2);

  typedef enum logic [1:0] {PORT_IDLE, PORT_WAIT, PORT_RESP} port_state_t;
  typedef logic [BANK_LOG2-1:0] index_t;
  typedef logic [CNT_W-1:0]     count_t;

  word_t bank [2][BANK_WORDS]; // Bank picked by address bit 2

  logic        req [2];
  addr_t       addr [2];
  word_t       wdata [2];
  strb_t       strb [2];
  logic        accept [2];
  count_t      delay [2];
  word_t       rdata [2];
  logic        conflict;

  port_state_t state [2];
  count_t      cnt [2];
  addr_t       addr_q [2];
  word_t       wdata_q [2];
  strb_t       strb_q [2];

  function automatic index_t word_index(addr_t a);
    return a[BANK_LOG2+2:3];
  endfunction

  assign req[0]   = mem0_req;
  assign addr[0]  = mem0_addr;
  assign wdata[0] = mem0_wdata;
  assign strb[0]  = mem0_strb;
  assign req[1]   = mem1_req;
  assign addr[1]  = mem1_addr;
  assign wdata[1] = mem1_wdata;
  assign strb[1]  = mem1_strb;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Port sequencing

  always_comb begin
    for (int n = 0; n < 2; n++) begin
      accept[n] = req[n] & (state[n] != PORT_WAIT); // Idle or finishing
    end
    conflict = accept[0] & accept[1] & (addr[0][2] == addr[1][2]);
    delay[0] = count_t'(`MEM_WAIT);
    delay[1] = count_t'(`MEM_WAIT) + count_t'(conflict); // Port 1 yields the bank
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      for (int n = 0; n < 2; n++) begin
        state[n] <= PORT_IDLE;
        cnt[n]   <= '0;
      end
    end else begin
      for (int n = 0; n < 2; n++) begin
        if (accept[n]) begin
          if (delay[n] == '0) begin
            state[n] <= PORT_RESP;
          end else begin
            state[n] <= PORT_WAIT;
            cnt[n]   <= delay[n] - count_t'(1);
          end
        end else begin
          case (state[n])
            PORT_WAIT: begin
              if (cnt[n] == '0) begin
                state[n] <= PORT_RESP;
              end else begin
                cnt[n] <= cnt[n] - count_t'(1);
              end
            end
            default: state[n] <= PORT_IDLE;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int n = 0; n < 2; n++) begin
      if (accept[n]) begin
        addr_q[n]  <= addr[n];
        wdata_q[n] <= wdata[n];
        strb_q[n]  <= strb[n];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage

  initial begin
    for (int i = 0; i < BANK_WORDS; i++) begin
      bank[0][i] = `MEM_INIT_WORD;
      bank[1][i] = `MEM_INIT_WORD;
    end
  end

  // Stores land at the end of the ready cycle, port 1 last
  always @(posedge clock) begin
    for (int n = 0; n < 2; n++) begin
      if (state[n] == PORT_RESP) begin
        for (int b = 0; b < 4; b++) begin
          if (strb_q[n][b]) begin
            bank[addr_q[n][2]][word_index(addr_q[n])][8*b +: 8] <= wdata_q[n][8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < 2; n++) begin
      rdata[n] = (state[n] == PORT_RESP) ? bank[addr_q[n][2]][word_index(addr_q[n])] : '0;
    end
  end

  assign mem0_ready = (state[0] == PORT_RESP);
  assign mem1_ready = (state[1] == PORT_RESP);
  assign mem0_rdata = rdata[0];
  assign mem1_rdata = rdata[1];

endmodule

//--- src/load_align.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module load_align import mem_access_pkg::*; (
  input  lsu_op_t    lsu_op,
  input  logic [1:0] byte_sel,
  input  word_t      rdata,
  output word_t      result
);

  logic [7:0]  byte_val;
  logic [15:0] half_val;

  always_comb begin
    byte_val = rdata[{byte_sel, 3'b000} +: 8];
    half_val = byte_sel[1] ? rdata[31:16] : rdata[15:0]; // Aligned halfword only
  end

  always_comb begin
    case (lsu_op)
      LSU_LB: begin
        result = {{(`MEM_XLEN-8){byte_val[7]}}, byte_val};
      end
      LSU_LBU: begin
        result = {{(`MEM_XLEN-8){1'b0}}, byte_val};
      end
      LSU_LH: begin
        result = {{(`MEM_XLEN-16){half_val[15]}}, half_val};
      end
      LSU_LHU: begin
        result = {{(`MEM_XLEN-16){1'b0}}, half_val};
      end
      default: begin
        result = rdata; // LW, and don't care otherwise
      end
    endcase
  end

endmodule

//--- src/mem_access_pkg.sv
`include "mem_config.svh"

package mem_access_pkg;

  typedef logic [`MEM_XLEN-1:0] word_t;
  typedef logic [`MEM_XLEN-1:0] addr_t;
  typedef logic [3:0]           strb_t;

  typedef enum logic [3:0] {
    LSU_NONE,
    LSU_LB,
    LSU_LH,
    LSU_LW,
    LSU_LBU,
    LSU_LHU,
    LSU_SB,
    LSU_SH,
    LSU_SW
  } lsu_op_t;

  function automatic logic is_load(lsu_op_t op);
    return (op == LSU_LB) || (op == LSU_LH) || (op == LSU_LW) ||
           (op == LSU_LBU) || (op == LSU_LHU);
  endfunction

  // Byte and halfword stores repeat across the word
  function automatic word_t store_word(lsu_op_t op, word_t sdata);
    case (op)
      LSU_SB:  return {(`MEM_XLEN/8){sdata[7:0]}};
      LSU_SH:  return {(`MEM_XLEN/16){sdata[15:0]}};
      default: return sdata;
    endcase
  endfunction

  function automatic strb_t store_strobe(lsu_op_t op, logic [1:0] byte_sel);
    case (op)
      LSU_SB:  return strb_t'(4'b0001 << byte_sel);
      LSU_SH:  return byte_sel[1] ? 4'b1100 : 4'b0011;
      LSU_SW:  return 4'b1111;
      default: return 4'b0000; // Loads and fences write nothing
    endcase
  endfunction

endpackage

//--- src/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Data and address width
`define MEM_XLEN 32

// Memory depth in words, log2
`define MEM_DEPTH_LOG2 10

// Extra wait cycles before ready
`define MEM_WAIT 0

// Power-up contents of every memory word
`define MEM_INIT_WORD 32'h0000_0000

`endif

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top import mem_access_pkg::*, pipe_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      clear,
  input  logic      ex0_valid,
  input  lsu_op_t   ex0_lsu_op,
  input  addr_t     ex0_addr,
  input  word_t     ex0_sdata,
  input  logic      ex0_wren,
  input  reg_addr_t ex0_waddr,
  input  word_t     ex0_wdata,
  input  pc_t       ex0_pc,
  input  logic      ex0_exception,
  input  ecause_t   ex0_ecause,
  input  logic      ex0_fence,
  input  logic      ex1_valid,
  input  lsu_op_t   ex1_lsu_op,
  input  addr_t     ex1_addr,
  input  word_t     ex1_sdata,
  input  logic      ex1_wren,
  input  reg_addr_t ex1_waddr,
  input  word_t     ex1_wdata,
  input  pc_t       ex1_pc,
  input  logic      ex1_exception,
  input  ecause_t   ex1_ecause,
  output logic      stall,
  output logic      fwd0_wren,
  output reg_addr_t fwd0_waddr,
  output word_t     fwd0_wdata,
  output logic      fwd1_wren,
  output reg_addr_t fwd1_waddr,
  output word_t     fwd1_wdata,
  output logic      wb0_valid,
  output logic      wb0_wren,
  output reg_addr_t wb0_waddr,
  output word_t     wb0_wdata,
  output logic      wb1_valid,
  output logic      wb1_wren,
  output reg_addr_t wb1_waddr,
  output word_t     wb1_wdata,
  output logic      exc_valid,
  output pc_t       exc_pc,
  output ecause_t   exc_ecause
);

  // Stage to memory
  logic       mem0_req;
  addr_t      mem0_addr;
  word_t      mem0_wdata;
  strb_t      mem0_strb;
  logic       mem0_ready;
  word_t      mem0_rdata;
  logic       mem1_req;
  addr_t      mem1_addr;
  word_t      mem1_wdata;
  strb_t      mem1_strb;
  logic       mem1_ready;
  word_t      mem1_rdata;

  // Stage to load units
  lsu_op_t    lsu0_op;
  logic [1:0] lsu0_byte_sel;
  word_t      lsu0_rdata;
  word_t      lsu0_result;
  lsu_op_t    lsu1_op;
  logic [1:0] lsu1_byte_sel;
  word_t      lsu1_rdata;
  word_t      lsu1_result;

  memory_stage u_stage (.*);

  load_align u_load0 (
    .lsu_op   (lsu0_op),
    .byte_sel (lsu0_byte_sel),
    .rdata    (lsu0_rdata),
    .result   (lsu0_result)
  );

  load_align u_load1 (
    .lsu_op   (lsu1_op),
    .byte_sel (lsu1_byte_sel),
    .rdata    (lsu1_rdata),
    .result   (lsu1_result)
  );

  data_tim u_dtim (.*);

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mem_access_pkg::*, pipe_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       clear,
  input  logic       ex0_valid,
  input  lsu_op_t    ex0_lsu_op,
  input  addr_t      ex0_addr,
  input  word_t      ex0_sdata,
  input  logic       ex0_wren,
  input  reg_addr_t  ex0_waddr,
  input  word_t      ex0_wdata,
  input  pc_t        ex0_pc,
  input  logic       ex0_exception,
  input  ecause_t    ex0_ecause,
  input  logic       ex0_fence,
  input  logic       ex1_valid,
  input  lsu_op_t    ex1_lsu_op,
  input  addr_t      ex1_addr,
  input  word_t      ex1_sdata,
  input  logic       ex1_wren,
  input  reg_addr_t  ex1_waddr,
  input  word_t      ex1_wdata,
  input  pc_t        ex1_pc,
  input  logic       ex1_exception,
  input  ecause_t    ex1_ecause,
  output logic       stall,
  output logic       mem0_req,
  output addr_t      mem0_addr,
  output word_t      mem0_wdata,
  output strb_t      mem0_strb,
  input  logic       mem0_ready,
  input  word_t      mem0_rdata,
  output logic       mem1_req,
  output addr_t      mem1_addr,
  output word_t      mem1_wdata,
  output strb_t      mem1_strb,
  input  logic       mem1_ready,
  input  word_t      mem1_rdata,
  output lsu_op_t    lsu0_op,
  output logic [1:0] lsu0_byte_sel,
  output word_t      lsu0_rdata,
  input  word_t      lsu0_result,
  output lsu_op_t    lsu1_op,
  output logic [1:0] lsu1_byte_sel,
  output word_t      lsu1_rdata,
  input  word_t      lsu1_result,
  output logic       fwd0_wren,
  output reg_addr_t  fwd0_waddr,
  output word_t      fwd0_wdata,
  output logic       fwd1_wren,
  output reg_addr_t  fwd1_waddr,
  output word_t      fwd1_wdata,
  output logic       wb0_valid,
  output logic       wb0_wren,
  output reg_addr_t  wb0_waddr,
  output word_t      wb0_wdata,
  output logic       wb1_valid,
  output logic       wb1_wren,
  output reg_addr_t  wb1_waddr,
  output word_t      wb1_wdata,
  output logic       exc_valid,
  output pc_t        exc_pc,
  output ecause_t    exc_ecause
);

  // Lane views of the execute inputs
  logic       ex_valid [2];
  lsu_op_t    ex_op [2];
  addr_t      ex_addr [2];
  word_t      ex_sdata [2];
  logic       ex_wren [2];
  reg_addr_t  ex_waddr [2];
  word_t      ex_wdata [2];
  pc_t        ex_pc [2];
  logic       ex_exc [2];
  ecause_t    ex_ecause [2];
  logic       mem_ready [2];
  word_t      lsu_result [2];

  logic       lane_valid [2];
  logic       ex_mem [2];
  logic       mem_req [2];
  logic       busy [2];
  logic       wait_lane [2];
  word_t      lane_data [2];
  logic       squash;
  logic       any_busy;
  logic       take;
  logic       pair_wait;
  logic       exc0_hit;
  logic       exc1_hit;

  // Pair held in the stage
  logic       s_valid [2];
  lsu_op_t    s_op [2];
  logic [1:0] s_byte_sel [2];
  logic       s_load [2];
  logic       s_wren [2];
  reg_addr_t  s_waddr [2];
  word_t      s_wdata [2];
  pc_t        s_pc [2];
  logic       s_exc [2];
  ecause_t    s_ecause [2];
  logic       own [2];   // Pair access not yet returned
  logic       outst [2]; // Port busy, cleared accesses included

  logic       wb_valid_q [2];
  logic       wb_wren_q [2];
  reg_addr_t  wb_waddr_q [2];
  word_t      wb_wdata_q [2];

  assign ex_valid[0]   = ex0_valid;
  assign ex_op[0]      = ex0_lsu_op;
  assign ex_addr[0]    = ex0_addr;
  assign ex_sdata[0]   = ex0_sdata;
  assign ex_wren[0]    = ex0_wren;
  assign ex_waddr[0]   = ex0_waddr;
  assign ex_wdata[0]   = ex0_wdata;
  assign ex_pc[0]      = ex0_pc;
  assign ex_exc[0]     = ex0_exception;
  assign ex_ecause[0]  = ex0_ecause;
  assign ex_valid[1]   = ex1_valid;
  assign ex_op[1]      = ex1_lsu_op;
  assign ex_addr[1]    = ex1_addr;
  assign ex_sdata[1]   = ex1_sdata;
  assign ex_wren[1]    = ex1_wren;
  assign ex_waddr[1]   = ex1_waddr;
  assign ex_wdata[1]   = ex1_wdata;
  assign ex_pc[1]      = ex1_pc;
  assign ex_exc[1]     = ex1_exception;
  assign ex_ecause[1]  = ex1_ecause;
  assign mem_ready[0]  = mem0_ready;
  assign mem_ready[1]  = mem1_ready;
  assign lsu_result[0] = lsu0_result;
  assign lsu_result[1] = lsu1_result;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Issue and stall

  always_comb begin
    squash        = ex_valid[0] & ex0_fence; // Fence kills its partner
    lane_valid[0] = ex_valid[0];
    lane_valid[1] = ex_valid[1] & ~squash;
    ex_mem[0]     = lane_valid[0] & ~ex_exc[0] & ((ex_op[0] != LSU_NONE) | ex0_fence);
    ex_mem[1]     = lane_valid[1] & ~ex_exc[1] & (ex_op[1] != LSU_NONE);
    for (int n = 0; n < 2; n++) begin
      busy[n]      = outst[n] & ~mem_ready[n];
      wait_lane[n] = own[n] & ~mem_ready[n];
    end
    any_busy  = busy[0] | busy[1];
    take      = ~clear & ~any_busy; // Stage advances at this edge
    pair_wait = wait_lane[0] | wait_lane[1];
    for (int n = 0; n < 2; n++) begin
      mem_req[n]   = take & ex_mem[n];
      lane_data[n] = (own[n] & s_load[n]) ? lsu_result[n] : s_wdata[n];
    end
    exc0_hit = s_valid[0] & s_exc[0];
    exc1_hit = s_valid[1] & s_exc[1];
  end

  assign stall = ~clear & any_busy;

  assign mem0_req   = mem_req[0];
  assign mem0_addr  = ex_addr[0];
  assign mem0_wdata = store_word(ex_op[0], ex_sdata[0]);
  assign mem0_strb  = store_strobe(ex_op[0], ex_addr[0][1:0]);
  assign mem1_req   = mem_req[1];
  assign mem1_addr  = ex_addr[1];
  assign mem1_wdata = store_word(ex_op[1], ex_sdata[1]);
  assign mem1_strb  = store_strobe(ex_op[1], ex_addr[1][1:0]);

  assign lsu0_op       = s_op[0];
  assign lsu0_byte_sel = s_byte_sel[0];
  assign lsu0_rdata    = mem0_rdata;
  assign lsu1_op       = s_op[1];
  assign lsu1_byte_sel = s_byte_sel[1];
  assign lsu1_rdata    = mem1_rdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Forwarding and exception report

  assign fwd0_wren  = s_valid[0] & s_wren[0] & ~pair_wait;
  assign fwd0_waddr = s_waddr[0];
  assign fwd0_wdata = lane_data[0];
  assign fwd1_wren  = s_valid[1] & s_wren[1] & ~pair_wait;
  assign fwd1_waddr = s_waddr[1];
  assign fwd1_wdata = lane_data[1];

  assign exc_valid  = (exc0_hit | exc1_hit) & ~pair_wait;
  assign exc_pc     = exc0_hit ? s_pc[0] : s_pc[1];         // Older lane first
  assign exc_ecause = exc0_hit ? s_ecause[0] : s_ecause[1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage and writeback registers

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      for (int n = 0; n < 2; n++) begin
        s_valid[n]    <= 1'b0;
        own[n]        <= 1'b0;
        outst[n]      <= 1'b0;
        wb_valid_q[n] <= 1'b0;
        wb_wren_q[n]  <= 1'b0;
      end
    end else begin
      for (int n = 0; n < 2; n++) begin
        outst[n] <= mem_req[n] | busy[n];
        own[n]   <= mem_req[n] | (~clear & wait_lane[n]); // Clear orphans the access
        if (clear) begin
          s_valid[n] <= 1'b0;
        end else if (take) begin
          s_valid[n] <= lane_valid[n];
        end
        wb_valid_q[n] <= take & s_valid[n];
        wb_wren_q[n]  <= take & s_valid[n] & s_wren[n];
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int n = 0; n < 2; n++) begin
      if (take) begin
        s_op[n]       <= ex_op[n];
        s_byte_sel[n] <= ex_addr[n][1:0];
        s_load[n]     <= is_load(ex_op[n]);
        s_wren[n]     <= ex_wren[n] & ~ex_exc[n];
        s_waddr[n]    <= ex_waddr[n];
        s_wdata[n]    <= ex_wdata[n];
        s_pc[n]       <= ex_pc[n];
        s_exc[n]      <= ex_exc[n];
        s_ecause[n]   <= ex_ecause[n];
        wb_waddr_q[n] <= s_waddr[n];
        wb_wdata_q[n] <= lane_data[n];
      end else if (own[n] & mem_ready[n] & s_load[n]) begin
        s_wdata[n] <= lsu_result[n]; // Keep early result while partner waits
      end
    end
  end

  assign wb0_valid = wb_valid_q[0];
  assign wb0_wren  = wb_wren_q[0];
  assign wb0_waddr = wb_waddr_q[0];
  assign wb0_wdata = wb_wdata_q[0];
  assign wb1_valid = wb_valid_q[1];
  assign wb1_wren  = wb_wren_q[1];
  assign wb1_waddr = wb_waddr_q[1];
  assign wb1_wdata = wb_wdata_q[1];

endmodule

//--- src/pipe_pkg.sv
package pipe_pkg;

  typedef logic [4:0]  reg_addr_t; // x0 to x31
  typedef logic [31:0] pc_t;
  typedef logic [3:0]  ecause_t;   // mcause code, low bits

endpackage

//--- tb/mem_stim.txt
# clr v0 op0 a0 sd0 we0 wa0 wd0 ex0 ec0 fen | v1 op1 a1 sd1 we1 wa1 wd1 ex1 ec1 | x0 x1
# hex; op 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu 6 sb 7 sh 8 sw; x is expected writeback data
0 1 0 0 0 1 1 11111111 0 0 0 1 0 0 0 1 2 22222222 0 0 11111111 22222222
0 1 0 0 0 1 3 cafe0001 0 0 0 1 0 0 0 0 4 0 0 0 cafe0001 0
0 1 8 100 a1b2c3d4 0 0 0 0 0 0 1 8 104 11223344 0 0 0 0 0 0 0
0 1 3 100 0 1 5 0 0 0 0 1 3 104 0 1 6 0 0 0 a1b2c3d4 11223344
0 1 6 101 ee 0 0 0 0 0 0 1 7 106 5566 0 0 0 0 0 0 0
0 1 3 100 0 1 5 0 0 0 0 1 3 104 0 1 6 0 0 0 a1b2eed4 55663344
0 1 1 100 0 1 7 0 0 0 0 1 1 101 0 1 8 0 0 0 ffffffd4 ffffffee
0 1 1 102 0 1 9 0 0 0 0 1 1 103 0 1 a 0 0 0 ffffffb2 ffffffa1
0 1 4 100 0 1 9 0 0 0 0 1 4 103 0 1 a 0 0 0 000000d4 000000a1
0 1 4 101 0 1 9 0 0 0 0 1 4 102 0 1 a 0 0 0 000000ee 000000b2
0 1 2 100 0 1 b 0 0 0 0 1 2 106 0 1 c 0 0 0 ffffeed4 00005566
0 1 5 102 0 1 b 0 0 0 0 1 5 104 0 1 c 0 0 0 0000a1b2 00003344
0 1 2 102 0 1 b 0 0 0 0 1 5 100 0 1 c 0 0 0 ffffa1b2 0000eed4
0 1 1 104 0 1 b 0 0 0 0 1 4 106 0 1 c 0 0 0 00000044 00000066
0 1 8 200 01020304 0 0 0 0 0 0 1 8 208 05060708 0 0 0 0 0 0 0
0 1 3 200 0 1 7 0 0 0 0 1 3 208 0 1 8 0 0 0 01020304 05060708
0 1 0 0 0 0 0 0 0 0 1 1 8 200 deadbeef 0 0 0 0 0 0 0
0 1 3 200 0 1 9 0 0 0 0 1 0 0 0 1 a 99 0 0 01020304 99
0 1 0 0 0 1 a a0a 0 0 0 1 8 104 ffffffff 0 0 0 1 7 a0a 0
0 1 3 100 0 1 b 0 1 5 0 1 0 0 0 1 c 0 1 6 0 0
0 1 8 100 0 0 0 0 1 6 0 1 0 0 0 1 d d 0 0 0 d
0 1 3 100 0 1 e 0 0 0 0 1 3 104 0 1 f 0 0 0 a1b2eed4 55663344
1 1 3 100 0 1 10 0 0 0 0 1 0 0 0 1 11 1111 0 0 0 0
1 1 0 0 0 1 12 12 0 0 0 1 0 0 0 1 13 13 0 0 0 0
0 1 0 0 0 1 14 14141414 0 0 0 1 0 0 0 1 15 15151515 0 0 14141414 15151515
0 1 3 208 0 1 16 0 0 0 0 1 4 20b 0 1 17 0 0 0 05060708 00000005
0 1 7 202 9988 0 0 0 0 0 0 1 6 20c 7f 0 0 0 0 0 0 0
0 1 2 202 0 1 18 0 0 0 0 1 3 20c 0 1 19 0 0 0 ffff9988 0000007f
0 1 0 0 0 1 1a 1a1a1a1a 0 0 0 1 0 0 0 1 1b 1b1b1b1b 0 0 1a1a1a1a 1b1b1b1b

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_subsystem import mem_access_pkg::*, pipe_pkg::*;;

  typedef struct packed {
    logic        wren0;
    reg_addr_t   waddr0;
    word_t       data0;
    logic        valid1;
    logic        wren1;
    reg_addr_t   waddr1;
    word_t       data1;
  } wb_exp_t;

  typedef struct packed {
    pc_t     pc;
    ecause_t cause;
  } exc_exp_t;

  logic clock, reset, clear;
  logic ex0_valid, ex0_wren, ex0_exception, ex0_fence;
  logic ex1_valid, ex1_wren, ex1_exception;
  lsu_op_t ex0_lsu_op, ex1_lsu_op;
  addr_t ex0_addr, ex1_addr;
  word_t ex0_sdata, ex0_wdata, ex1_sdata, ex1_wdata;
  reg_addr_t ex0_waddr, ex1_waddr;
  pc_t ex0_pc, ex1_pc;
  ecause_t ex0_ecause, ex1_ecause;
  logic stall, fwd0_wren, fwd1_wren, wb0_valid, wb0_wren, wb1_valid, wb1_wren, exc_valid;
  reg_addr_t fwd0_waddr, fwd1_waddr, wb0_waddr, wb1_waddr;
  word_t fwd0_wdata, fwd1_wdata, wb0_wdata, wb1_wdata;
  pc_t exc_pc;
  ecause_t exc_ecause;

  string    rows [$];
  wb_exp_t  wb_q [$];
  exc_exp_t exc_q [$];
  int       n_rows = 0;
  int       seed = 32'h06cc53e8;
  logic     stall_seen = 1'b0;

  mem_subsystem_top u_dut (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock; // 8 ns period

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare_value(input string what, input word_t got, input word_t expv);
    assert (got === expv) else
      fail_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, expv));
  endtask

  task automatic drive_idle();
    ex0_valid = 1'b0;
    ex0_lsu_op = LSU_NONE;
    ex0_addr = '0;
    ex0_sdata = '0;
    ex0_wren = 1'b0;
    ex0_waddr = '0;
    ex0_wdata = '0;
    ex0_pc = '0;
    ex0_exception = 1'b0;
    ex0_ecause = '0;
    ex0_fence = 1'b0;
    ex1_valid = 1'b0;
    ex1_lsu_op = LSU_NONE;
    ex1_addr = '0;
    ex1_sdata = '0;
    ex1_wren = 1'b0;
    ex1_waddr = '0;
    ex1_wdata = '0;
    ex1_pc = '0;
    ex1_exception = 1'b0;
    ex1_ecause = '0;
  endtask

  // Presents one pair and returns on the falling edge after it was taken
  task automatic present_row(input int idx, input string line);
    logic [31:0] f [22];
    int          cols;
    wb_exp_t     wexp;
    exc_exp_t    eexp;
    logic        alu_only;
    pc_t         pc0;
    cols = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                   f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                   f[20], f[21]);
    if (cols != 22) begin
      fail_run($sformatf("Stimulus line %0d does not have 22 columns", idx));
    end
    pc0 = 32'h1000 + 32'(8 * idx);
    clear = 1'b0;
    ex0_valid = f[1][0];
    ex0_lsu_op = lsu_op_t'(f[2][3:0]);
    ex0_addr = f[3];
    ex0_sdata = f[4];
    ex0_wren = f[5][0];
    ex0_waddr = f[6][4:0];
    ex0_wdata = f[7];
    ex0_pc = pc0;
    ex0_exception = f[8][0];
    ex0_ecause = f[9][3:0];
    ex0_fence = f[10][0];
    ex1_valid = f[11][0];
    ex1_lsu_op = lsu_op_t'(f[12][3:0]);
    ex1_addr = f[13];
    ex1_sdata = f[14];
    ex1_wren = f[15][0];
    ex1_waddr = f[16][4:0];
    ex1_wdata = f[17];
    ex1_pc = pc0 + 32'd4;
    ex1_exception = f[18][0];
    ex1_ecause = f[19][3:0];

    // Fence squashes lane 1 and an exception blocks the register write
    wexp.wren0  = f[1][0] & f[5][0] & ~f[8][0];
    wexp.waddr0 = f[6][4:0];
    wexp.data0  = f[20];
    wexp.valid1 = f[11][0] & ~(f[1][0] & f[10][0]);
    wexp.wren1  = wexp.valid1 & f[15][0] & ~f[18][0];
    wexp.waddr1 = f[16][4:0];
    wexp.data1  = f[21];
    alu_only = (f[2] == 0) && (f[12] == 0) && !f[10][0] && !f[8][0] && !f[18][0];

    while (stall) begin
      @(negedge clock);
    end

    if (f[0][0]) begin
      @(negedge clock); // Pair now in the stage
      drive_idle();
      clear = 1'b1;
      @(negedge clock);
      clear = 1'b0;
      @(negedge clock); // Idle cycle after the clear
    end else begin
      wb_q.push_back(wexp);
      if (f[1][0] && f[8][0]) begin
        eexp.pc = pc0;
        eexp.cause = f[9][3:0];
        exc_q.push_back(eexp);
      end else if (wexp.valid1 && f[18][0]) begin
        eexp.pc = pc0 + 32'd4;
        eexp.cause = f[19][3:0];
        exc_q.push_back(eexp);
      end
      @(negedge clock);
      if (alu_only) begin
        compare_value("fwd0_wren", 32'(fwd0_wren), 32'(wexp.wren0));
        compare_value("fwd1_wren", 32'(fwd1_wren), 32'(wexp.wren1));
        if (wexp.wren0) begin
          compare_value("fwd0_waddr", 32'(fwd0_waddr), 32'(wexp.waddr0));
          compare_value("fwd0_wdata", fwd0_wdata, wexp.data0);
        end
        if (wexp.wren1) begin
          compare_value("fwd1_waddr", 32'(fwd1_waddr), 32'(wexp.waddr1));
          compare_value("fwd1_wdata", fwd1_wdata, wexp.data1);
        end
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result monitors

  always @(negedge clock) begin : check_outputs
    wb_exp_t  wexp;
    exc_exp_t eexp;
    if (reset && stall) begin
      stall_seen = 1'b1;
    end
    if (reset && wb0_valid) begin
      assert (wb_q.size() != 0) else fail_run("A writeback appeared with no pair pending");
      wexp = wb_q.pop_front();
      compare_value("wb0_wren", 32'(wb0_wren), 32'(wexp.wren0));
      compare_value("wb1_valid", 32'(wb1_valid), 32'(wexp.valid1));
      compare_value("wb1_wren", 32'(wb1_wren), 32'(wexp.wren1));
      if (wexp.wren0) begin
        compare_value("wb0_waddr", 32'(wb0_waddr), 32'(wexp.waddr0));
        compare_value("wb0_wdata", wb0_wdata, wexp.data0);
      end
      if (wexp.wren1) begin
        compare_value("wb1_waddr", 32'(wb1_waddr), 32'(wexp.waddr1));
        compare_value("wb1_wdata", wb1_wdata, wexp.data1);
      end
    end
    assert (!(reset && wb1_valid && !wb0_valid)) else
      fail_run("Lane 1 retired without lane 0");
    if (reset && exc_valid && !stall) begin // Pair leaves at the next edge
      assert (exc_q.size() != 0) else fail_run("An exception was reported for a clean pair");
      eexp = exc_q.pop_front();
      compare_value("exc_pc", exc_pc, eexp.pc);
      compare_value("exc_ecause", 32'(exc_ecause), 32'(eexp.cause));
    end
  end

  initial begin : watchdog
    longint limit;
    wait (n_rows > 0);
    limit = longint'(n_rows) * (4 + `MEM_WAIT) * 8 + 200;
    #(limit);
    $display("Timeout: the run hung after %0d ns", limit);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence

  initial begin : stimulus
    int    fd;
    int    gap;
    string line;
    drive_idle();
    clear = 1'b0;
    reset = 1'b0;
    fd = $fopen("tb/mem_stim.txt", "r");
    if (fd == 0) begin
      fail_run("The stimulus file tb/mem_stim.txt could not be opened");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != 8'h23) begin // Skip comments
        rows.push_back(line);
      end
    end
    $fclose(fd);
    if (rows.size() == 0) begin
      fail_run("The stimulus file holds no pairs");
    end
    n_rows = rows.size();

    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    for (int i = 0; i < n_rows; i++) begin
      gap = int'($unsigned($random(seed)) % 3);
      if (gap != 0) begin
        drive_idle();
        repeat (gap) @(negedge clock);
        while (stall) begin
          @(negedge clock);
        end
      end
      present_row(i, rows[i]);
    end
    drive_idle();
    while (wb_q.size() != 0 || exc_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (4) @(negedge clock);

    if (!stall_seen) begin
      fail_run("Stall never rose during the dual-access pairs");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+src
src/mem_access_pkg.sv
src/pipe_pkg.sv
src/load_align.sv
src/data_tim.sv
src/memory_stage.sv
src/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv
